//--- sim.f
+incdir+.
miniAluPkg.sv
instructionRom.sv
dataRam.sv
lcdTimer.sv
lcdController.sv
miniAlu.sv
tbMiniAlu.sv

//--- run.sh
#!/bin/sh
# Build and run the miniAlu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -f sim.f --top-module tbMiniAlu -o simMiniAlu

./obj_dir/simMiniAlu > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "Test passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation finished cleanly"

//--- tbMiniAlu.sv
`include "miniAlu_defines.svh"

module tbMiniAlu
	import miniAluPkg::*;
();

	localparam int clockPeriod = 100;

	// Worst case per byte is two nibbles plus the longest gap
	localparam int byteCycles = 2 * (`LCD_E_HIGH + `LCD_NIBBLE_WAIT + 1)
		+ `LCD_BYTE_WAIT + `LCD_CLEAR_WAIT;
	localparam int watchdogCycles = `LCD_POWERUP_WAIT + 9 * byteCycles + 2000;

	logic       Clock;
	logic       reset;
	logic [7:0] led;
	lcdPins_t   lcdBus;

	logic [4:0] nibbleQueue[$];   // {registerSelect, data}
	logic [7:0] ledQueue[$];      // Distinct led values since reset
	logic [4:0] heldNibble;
	logic       enableWasHigh;
	logic [7:0] lastLed;

	miniAlu i_miniAlu
	(
		.Clock(  Clock  ),
		.reset(  reset  ),
		.led(    led    ),
		.lcdBus( lcdBus )
	);

	always #(clockPeriod / 2) Clock = ~Clock;

	// ----------------------------------------
	// Bus and LED monitor
	// ----------------------------------------
	always @(negedge Clock)
	begin
		if (reset)
		begin
			nibbleQueue.delete();
			ledQueue.delete();
			enableWasHigh = 1'b0;
			lastLed       = 8'h00;
		end
		else
		begin
			if (enableWasHigh && !lcdBus.enable)   // Enable just fell
				nibbleQueue.push_back(heldNibble);
			if (lcdBus.enable)
				heldNibble = {lcdBus.registerSelect, lcdBus.data};
			enableWasHigh = lcdBus.enable;
			if (led !== lastLed)
			begin
				ledQueue.push_back(led);
				lastLed = led;
			end
		end
	end

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("Timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
		$display("Test failed");
		$fatal(1, "Simulation stopped by the watchdog");
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
			$display("Test failed");
			$fatal(1, "Stopping at the first error");
		end
	endtask

	task automatic checkResetOutputs();
		checkValue("led", 32'(led), 32'h0);
		checkValue("lcdBus.enable", 32'(lcdBus.enable), 32'h0);
		checkValue("lcdBus.readWrite", 32'(lcdBus.readWrite), 32'h0);
		checkValue("lcdBus.flashControl", 32'(lcdBus.flashControl), 32'h1);
	endtask

	// Reset was raised at a falling edge or at time zero
	task automatic holdReset(input int unsigned cycles);
		repeat (cycles)
		begin
			@(negedge Clock);
			checkResetOutputs();
		end
		reset = 1'b0;
	endtask

	task automatic popNibble(output logic [4:0] entry);
		while (nibbleQueue.size() == 0)
			@(negedge Clock);
		entry = nibbleQueue.pop_front();
	endtask

	task automatic expectNibble(input logic [3:0] expected, input logic select);
		logic [4:0] entry;
		popNibble(entry);
		checkValue("lcdBus.data", 32'(entry[3:0]), 32'(expected));
		checkValue("lcdBus.registerSelect", 32'(entry[4]), 32'(select));
	endtask

	// High nibble arrives first
	task automatic expectByte(input logic [7:0] expected, input logic select);
		logic [4:0] high;
		logic [4:0] low;
		popNibble(high);
		popNibble(low);
		checkValue("lcd byte", 32'({high[3:0], low[3:0]}), 32'(expected));
		checkValue("lcdBus.registerSelect", 32'(high[4]), 32'(select));
		checkValue("lcdBus.registerSelect", 32'(low[4]), 32'(select));
	endtask

	task automatic expectLed(input logic [7:0] expected);
		logic [7:0] value;
		while (ledQueue.size() == 0)
			@(negedge Clock);
		value = ledQueue.pop_front();
		checkValue("led", 32'(value), 32'(expected));
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic resetState();
		holdReset(4);
	endtask

	task automatic lcdInit();
		logic [3:0] initNibbles[4];
		logic [7:0] initBytes[4];
		initNibbles = '{4'h3, 4'h3, 4'h3, 4'h2};
		initBytes   = '{8'h28, 8'h06, 8'h0C, 8'h01};
		foreach (initNibbles[i])
			expectNibble(initNibbles[i], 1'b0);
		foreach (initBytes[i])
			expectByte(initBytes[i], 1'b0);
	endtask

	task automatic ledCount();
		logic [15:0] counter;
		counter = 16'd1;
		do
		begin
			expectLed(counter[7:0]);   // LED step shows r1
			counter = counter + 16'd1;
		end
		while (counter <= 16'd5);
	endtask

	task automatic lcdData();
		expectByte(8'h48 - 8'h01, 1'b1);
		expectByte(8'h69, 1'b1);
	endtask

	task automatic finalLed();
		expectLed(8'hA5);
		repeat (200)
		begin
			@(negedge Clock);
			checkValue("led", 32'(led), 32'hA5);
		end
		checkValue("led changes", 32'(ledQueue.size()), 32'h0);
		checkValue("extra lcd nibbles", 32'(nibbleQueue.size()), 32'h0);
	endtask

	task automatic resetRestart();
		int unsigned resetCycles;
		resetCycles = 4 + ($urandom % 5);
		$display("Reset pulse of %0d cycles", resetCycles);
		@(negedge Clock);
		reset = 1'b1;
		holdReset(resetCycles);
		lcdInit();
		ledCount();
	endtask

	initial
	begin
		Clock = 1'b0;
		reset = 1'b1;
		void'($urandom(41));
		resetState();
		lcdInit();
		ledCount();
		lcdData();
		finalLed();
		resetRestart();
		$display("Test passed");
		$finish;
	end

endmodule

//--- miniAlu.sv
`include "miniAlu_defines.svh"

module miniAlu
	import miniAluPkg::*;
(
	input  logic       Clock,
	input  logic       reset,
	output logic [7:0] led,
	output lcdPins_t   lcdBus
);

	logic [`IP_WIDTH-1:0]   instructionPointer;
	logic [`IP_WIDTH-1:0]   branchTarget;
	instruction_t           romInstruction;
	instruction_t           currentInstruction;   // Fetch register
	opcode_t                opcode;
	logic [`DATA_WIDTH-1:0] source1Data;
	logic [`DATA_WIDTH-1:0] source0Data;
	logic [`DATA_WIDTH-1:0] result;
	logic                   writeEnable;
	logic                   branchTaken;
	logic                   ledLoad;
	logic                   lcdWrite;
	logic [7:0]             lcdData;
	logic                   ready;

	instructionRom programRom
	(
		.address(     instructionPointer ),
		.instruction( romInstruction     )
	);

	dataRam registerFile
	(
		.Clock(        Clock                                  ),
		.writeEnable(  writeEnable                            ),
		.readAddress0( currentInstruction.regView.source0     ),
		.readAddress1( currentInstruction.regView.source1     ),
		.writeAddress( currentInstruction.regView.destination ),
		.writeData(    result                                 ),
		.readData0(    source0Data                            ),
		.readData1(    source1Data                            )
	);

	lcdController lcd
	(
		.Clock(  Clock    ),
		.reset(  reset    ),
		.write(  lcdWrite ),
		.data(   lcdData  ),
		.lcdBus( lcdBus   ),
		.ready(  ready    )
	);

	assign opcode  = currentInstruction.regView.opcode;
	assign lcdData = source1Data[7:0];
	assign branchTarget =
		{{(`IP_WIDTH - `REG_ADDR_WIDTH){1'b0}}, currentInstruction.regView.destination};

	// ----------------------------------------
	// Fetch, stall and flush
	// ----------------------------------------
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			instructionPointer         <= '0;
			currentInstruction.regView <= '{NOP, '0, '0, '0};
		end
		else if (ready)   // Hold both while the LCD is busy
		begin
			if (branchTaken)
			begin
				instructionPointer         <= branchTarget;
				currentInstruction.regView <= '{NOP, '0, '0, '0};   // One bubble
			end
			else
			begin
				instructionPointer <= instructionPointer + 1'b1;
				currentInstruction <= romInstruction;
			end
		end
	end

	// ----------------------------------------
	// Execute
	// ----------------------------------------
	always_comb
	begin
		writeEnable = 1'b0;
		result      = '0;
		branchTaken = 1'b0;
		ledLoad     = 1'b0;
		lcdWrite    = 1'b0;
		if (ready)
		begin
			case (opcode)
				ADD:
				begin
					writeEnable = 1'b1;
					result      = source1Data + source0Data;
				end
				SUB:
				begin
					writeEnable = 1'b1;
					result      = source1Data - source0Data;
				end
				STO:
				begin
					writeEnable = 1'b1;
					result      = currentInstruction.immView.immediate;
				end
				BLE:     branchTaken = (source1Data <= source0Data);
				JMP:     branchTaken = 1'b1;
				LED:     ledLoad     = 1'b1;
				LCD:     lcdWrite    = 1'b1;   // Byte is source1 low half
				default: ;
			endcase
		end
	end

	always_ff @(posedge Clock)
	begin
		if (reset)
			led <= '0;
		else if (ledLoad)
			led <= source1Data[7:0];
	end

endmodule

//--- lcdController.sv
`include "miniAlu_defines.svh"

module lcdController
	import miniAluPkg::*;
(
	input  logic       Clock,
	input  logic       reset,
	input  logic       write,
	input  logic [7:0] data,
	output lcdPins_t   lcdBus,
	output logic       ready
);

	typedef enum logic [2:0]
	{
		POWERUP_WAIT,
		INIT_NIBBLE,
		INIT_COMMAND,
		IDLE,
		NIBBLE_SETUP,
		ENABLE_HIGH,
		NIBBLE_GAP
	} state_t;

	state_t                      state;
	state_t                      nextState;
	logic [3:0]                  initStep;       // 0-3 nibbles, 4-7 commands, 8 done
	logic [7:0]                  byteReg;
	logic                        highNibble;     // High half on the bus
	logic                        singleNibble;   // Init nibble, no low half
	logic                        dataMode;
	logic                        timerLoad;
	logic [`LCD_TIMER_WIDTH-1:0] timerCount;
	logic [`LCD_TIMER_WIDTH-1:0] gapCount;
	logic                        expired;

	// A wait state lasts the loaded count plus two cycles
	function automatic logic [`LCD_TIMER_WIDTH-1:0] ticks(input int cycles);
		return `LCD_TIMER_WIDTH'(cycles - 2);
	endfunction

	function automatic logic [7:0] initCommand(input logic [1:0] index);
		case (index)
			2'd0:    return 8'h28;   // 4-bit bus, 2 lines
			2'd1:    return 8'h06;   // Auto increment
			2'd2:    return 8'h0C;   // Display on
			default: return 8'h01;   // Clear
		endcase
	endfunction

	lcdTimer delayTimer
	(
		.Clock(   Clock      ),
		.reset(   reset      ),
		.load(    timerLoad  ),
		.count(   timerCount ),
		.expired( expired    )
	);

	// ----------------------------------------
	// Next state and timer load
	// ----------------------------------------
	always_comb
	begin
		if (highNibble || singleNibble)
			gapCount = ticks(`LCD_NIBBLE_WAIT);
		else if (!dataMode && byteReg == 8'h01)
			gapCount = ticks(`LCD_CLEAR_WAIT);
		else
			gapCount = ticks(`LCD_BYTE_WAIT);
	end

	always_comb
	begin
		nextState  = state;
		timerLoad  = 1'b0;
		timerCount = gapCount;
		case (state)
			POWERUP_WAIT:
				if (expired)
				begin
					timerLoad  = 1'b1;
					timerCount = ticks(`LCD_POWERUP_WAIT);
					nextState  = NIBBLE_GAP;   // Power-up delay runs as a gap
				end
			INIT_NIBBLE, INIT_COMMAND:
				nextState = NIBBLE_SETUP;
			IDLE:
				if (write)
					nextState = NIBBLE_SETUP;
			NIBBLE_SETUP:
			begin
				timerLoad  = 1'b1;
				timerCount = ticks(`LCD_E_HIGH);
				nextState  = ENABLE_HIGH;
			end
			ENABLE_HIGH:
				if (expired)
				begin
					timerLoad = 1'b1;
					nextState = NIBBLE_GAP;
				end
			NIBBLE_GAP:
				if (expired)
				begin
					if (highNibble)
						nextState = NIBBLE_SETUP;   // Low half follows
					else if (initStep < 4'd4)
						nextState = INIT_NIBBLE;
					else if (initStep < 4'd8)
						nextState = INIT_COMMAND;
					else
						nextState = IDLE;
				end
			default:
				nextState = POWERUP_WAIT;
		endcase
	end

	// ----------------------------------------
	// Control registers
	// ----------------------------------------
	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			state        <= POWERUP_WAIT;
			initStep     <= '0;
			highNibble   <= 1'b0;
			singleNibble <= 1'b0;
			dataMode     <= 1'b0;
			ready        <= 1'b0;
		end
		else
		begin
			state <= nextState;
			ready <= (nextState == IDLE);
			case (state)
				INIT_NIBBLE:
				begin
					singleNibble <= 1'b1;
					highNibble   <= 1'b0;
					dataMode     <= 1'b0;
					initStep     <= initStep + 1'b1;
				end
				INIT_COMMAND:
				begin
					singleNibble <= 1'b0;
					highNibble   <= 1'b1;
					dataMode     <= 1'b0;
					initStep     <= initStep + 1'b1;
				end
				IDLE:
					if (write)
					begin
						singleNibble <= 1'b0;
						highNibble   <= 1'b1;
						dataMode     <= 1'b1;
					end
				NIBBLE_GAP:
					if (expired)
						highNibble <= 1'b0;
				default: ;
			endcase
		end
	end

	// Byte being sent
	always_ff @(posedge Clock)
	begin
		case (state)
			INIT_NIBBLE:  byteReg <= {4'h0, ((initStep == 4'd3) ? 4'h2 : 4'h3)};
			INIT_COMMAND: byteReg <= initCommand(initStep[1:0]);
			IDLE:
				if (write)
					byteReg <= data;
			default: ;
		endcase
	end

	always_comb
	begin
		lcdBus.enable         = (state == ENABLE_HIGH);
		lcdBus.registerSelect = dataMode;
		lcdBus.readWrite      = 1'b0;   // Write only
		lcdBus.flashControl   = 1'b1;   // Keep StrataFlash off the bus
		lcdBus.data           = highNibble ? byteReg[7:4] : byteReg[3:0];
	end

endmodule

//--- lcdTimer.sv
`include "miniAlu_defines.svh"

module lcdTimer
(
	input  logic                        Clock,
	input  logic                        reset,
	input  logic                        load,
	input  logic [`LCD_TIMER_WIDTH-1:0] count,
	output logic                        expired
);

	logic [`LCD_TIMER_WIDTH-1:0] remaining;

	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			remaining <= '0;
			expired   <= 1'b1;   // Idle timer reads as done
		end
		else if (load)
		begin
			remaining <= count;
			expired   <= 1'b0;
		end
		else if (remaining != '0)
		begin
			remaining <= remaining - 1'b1;
		end
		else
		begin
			// Flag follows zero by one cycle and then sticks
			expired <= 1'b1;
		end
	end

endmodule

//--- dataRam.sv
`include "miniAlu_defines.svh"

module dataRam
(
	input  logic                       Clock,
	input  logic                       writeEnable,
	input  logic [`REG_ADDR_WIDTH-1:0] readAddress0,
	input  logic [`REG_ADDR_WIDTH-1:0] readAddress1,
	input  logic [`REG_ADDR_WIDTH-1:0] writeAddress,
	input  logic [`DATA_WIDTH-1:0]     writeData,
	output logic [`DATA_WIDTH-1:0]     readData0,
	output logic [`DATA_WIDTH-1:0]     readData1
);

	localparam int DEPTH = 1 << `REG_ADDR_WIDTH;

	logic [`DATA_WIDTH-1:0] memory [0:DEPTH-1];

	// Write lands at the clock edge
	always_ff @(posedge Clock)
	begin
		if (writeEnable)
			memory[writeAddress] <= writeData;
	end

	// Both read ports are combinational
	always_comb
	begin
		readData0 = memory[readAddress0];
		readData1 = memory[readAddress1];
	end

endmodule

//--- instructionRom.sv
`include "miniAlu_defines.svh"

module instructionRom
	import miniAluPkg::*;
(
	input  logic [`IP_WIDTH-1:0] address,
	output instruction_t         instruction
);

	function automatic instruction_t regOp
	(
		input opcode_t                    op,
		input logic [`REG_ADDR_WIDTH-1:0] destination,
		input logic [`REG_ADDR_WIDTH-1:0] source1,
		input logic [`REG_ADDR_WIDTH-1:0] source0
	);
		instruction_t word;
		word.regView = '{op, destination, source1, source0};
		return word;
	endfunction

	function automatic instruction_t immOp
	(
		input opcode_t                    op,
		input logic [`REG_ADDR_WIDTH-1:0] destination,
		input logic [`DATA_WIDTH-1:0]     immediate
	);
		instruction_t word;
		word.immView = '{op, destination, immediate};
		return word;
	endfunction

	always_comb
	begin
		case (address)
			16'd0:   instruction = immOp(STO, 8'd1, 16'd1);
			16'd1:   instruction = immOp(STO, 8'd2, 16'd5);       // Loop limit
			16'd2:   instruction = immOp(STO, 8'd3, 16'd1);
			16'd3:   instruction = immOp(STO, 8'd4, 16'h0048);    // 'H'
			16'd4:   instruction = regOp(LED, 8'd0, 8'd1, 8'd0);
			16'd5:   instruction = regOp(ADD, 8'd1, 8'd1, 8'd3);
			16'd6:   instruction = regOp(BLE, 8'd4, 8'd1, 8'd2);  // Back to LED while r1 <= r2
			16'd7:   instruction = regOp(SUB, 8'd4, 8'd4, 8'd3);  // 'G'
			16'd8:   instruction = immOp(STO, 8'd5, 16'h0069);    // 'i'
			16'd9:   instruction = regOp(LCD, 8'd0, 8'd4, 8'd0);
			16'd10:  instruction = regOp(LCD, 8'd0, 8'd5, 8'd0);
			16'd11:  instruction = immOp(STO, 8'd6, 16'h00A5);
			16'd12:  instruction = regOp(LED, 8'd0, 8'd6, 8'd0);
			16'd13:  instruction = regOp(JMP, 8'd13, 8'd0, 8'd0); // Park
			default: instruction = regOp(NOP, 8'd0, 8'd0, 8'd0);
		endcase
	end

endmodule

//--- miniAluPkg.sv
`include "miniAlu_defines.svh"

package miniAluPkg;

	typedef enum logic [3:0]
	{
		NOP = 4'd0,
		LED = 4'd1,   // led <= source1 low byte
		BLE = 4'd2,   // Branch if source1 <= source0
		STO = 4'd3,   // Load immediate
		ADD = 4'd4,
		JMP = 4'd5,
		SUB = 4'd6,
		LCD = 4'd7    // Send source1 low byte as data
	} opcode_t;

	// Three register addresses
	typedef struct packed
	{
		opcode_t                    opcode;
		logic [`REG_ADDR_WIDTH-1:0] destination;
		logic [`REG_ADDR_WIDTH-1:0] source1;
		logic [`REG_ADDR_WIDTH-1:0] source0;
	} regForm_t;

	// Destination plus immediate
	typedef struct packed
	{
		opcode_t                    opcode;
		logic [`REG_ADDR_WIDTH-1:0] destination;
		logic [`DATA_WIDTH-1:0]     immediate;
	} immForm_t;

	// 28-bit instruction word, opcode in the top nibble of both views
	typedef union packed
	{
		regForm_t regView;
		immForm_t immView;
	} instruction_t;

	typedef struct packed
	{
		logic       enable;
		logic       registerSelect;   // Low for command, high for data
		logic       readWrite;
		logic       flashControl;     // StrataFlash chip enable
		logic [3:0] data;
	} lcdPins_t;

endpackage

//--- miniAlu_defines.svh
`ifndef MINIALU_DEFINES_SVH
`define MINIALU_DEFINES_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define DATA_WIDTH      16   // Register and ALU result
`define REG_ADDR_WIDTH  8    // 256 registers
`define IP_WIDTH        16

// ----------------------------------------
// LCD timing
// ----------------------------------------
// Counts in clock cycles, each at least 2
`define LCD_TIMER_WIDTH 20

// Power-up settle before the first init nibble
`define LCD_POWERUP_WAIT  40
`define LCD_E_HIGH        3    // Enable pulse width
`define LCD_NIBBLE_WAIT   4    // Gap after every nibble

// Gap after a complete byte
`define LCD_BYTE_WAIT     10

// Clear display needs the longest gap
`define LCD_CLEAR_WAIT    30

`endif
